// File: include/fifo_config.svh
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// width of one stream word
`define FIFO_WIDTH 20

// 32 entries in the buffer memory
`define FIFO_DEPTH_LOG2 5

// byte address into the register map, word aligned
`define APB_ADDR_WIDTH 4

`endif

// File: src/apb_pkg.sv
`default_nettype none

`include "fifo_config.svh"

package apb_pkg;

    // byte offsets of the host-visible registers
    typedef enum logic [`APB_ADDR_WIDTH-1:0] {
        REG_DATA   = 'h0, // write pushes one word
        REG_STATUS = 'h4, // level, empty and full
        REG_FLUSH  = 'h8  // write drops every stored word
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WAIT_SPACE // data write parked until the buffer has room
    } apb_state_e;

endpackage

`default_nettype wire

// File: src/fifo_pkg.sv
`default_nettype none

`include "fifo_config.svh"

package fifo_pkg;

    typedef logic [`FIFO_WIDTH-1:0] word_t;

    typedef logic [`FIFO_DEPTH_LOG2-1:0] ptr_t;

    // one bit wider than a pointer so that a full buffer can be counted
    typedef logic [`FIFO_DEPTH_LOG2:0] level_t;

    typedef enum logic [1:0] {
        EMPTY, // nothing held for the stream
        FETCH, // memory read in flight
        HOLD   // word on out_data until taken
    } cons_state_e;

endpackage

`default_nettype wire

// File: src/memory_block.sv
`default_nettype none

module memory_block #(
    parameter int WIDTH      = 20,
    parameter int DEPTH_LOG2 = 5
) (
    input  wire                  clk,

    input  wire                  write_enable,
    input  wire [DEPTH_LOG2-1:0] write_addr,
    input  wire [WIDTH-1:0]      data_in,

    input  wire                  read_stall,
    input  wire [DEPTH_LOG2-1:0] read_addr,
    output logic [WIDTH-1:0]     data_out
);

    logic [WIDTH-1:0] mem [0:(1 << DEPTH_LOG2)-1];

    logic                  write_enable_q;
    logic [DEPTH_LOG2-1:0] write_addr_q;
    logic [WIDTH-1:0]      write_data_q;

    logic [DEPTH_LOG2-1:0] read_addr_q;

    // the write side goes through an input register before it reaches the array
    always_ff @(posedge clk) begin
        write_enable_q <= write_enable;
        write_addr_q   <= write_addr;
        write_data_q   <= data_in;
        if (write_enable_q) begin
            mem[write_addr_q] <= write_data_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!read_stall) begin
            read_addr_q <= read_addr; // held between reads so data_out stays put
        end
    end

    assign data_out = mem[read_addr_q]; // unregistered output, one cycle after the address

endmodule

`default_nettype wire

// File: src/fifo_buffer.sv
`default_nettype none

`include "fifo_config.svh"

module fifo_buffer (
    input  wire               clk,
    input  wire               reset,

    input  wire               push,
    input  wire fifo_pkg::word_t push_data,
    input  wire               flush,

    input  wire               pop,
    output fifo_pkg::word_t   rd_data,

    output fifo_pkg::level_t  level,
    output logic              full,
    output logic              empty,
    output logic              can_pop
);

    localparam fifo_pkg::level_t DEPTH = fifo_pkg::level_t'(1 << `FIFO_DEPTH_LOG2);

    fifo_pkg::ptr_t   wr_ptr;
    fifo_pkg::ptr_t   rd_ptr;
    fifo_pkg::level_t level_q;
    logic             recent_write;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            level_q <= '0;
        end else begin
            case ({push, pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q; // both or neither leave the count alone
            endcase
        end
    end

    // a word pushed last cycle is counted but still sits in the memory input register
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            recent_write <= 1'b0;
        end else begin
            recent_write <= push;
        end
    end

    assign level   = level_q;
    assign full    = (level_q == DEPTH);
    assign empty   = (level_q == '0);
    assign can_pop = (level_q > fifo_pkg::level_t'(recent_write));

    memory_block #(
        .WIDTH      (`FIFO_WIDTH),
        .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
    ) memory (
        .clk          (clk),
        .write_enable (push),
        .write_addr   (wr_ptr),
        .data_in      (push_data),
        .read_stall   (!pop), // only a pop moves the read address on
        .read_addr    (rd_ptr),
        .data_out     (rd_data)
    );

endmodule

`default_nettype wire

// File: src/apb_producer.sv
`default_nettype none

`include "fifo_config.svh"

module apb_producer (
    input  wire                       clk,
    input  wire                       reset,

    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [`APB_ADDR_WIDTH-1:0] paddr,
    input  wire [31:0]                pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,

    output logic                      push,
    output fifo_pkg::word_t           push_data,
    output logic                      flush,
    input  wire                       full,
    input  wire                       empty,
    input  wire fifo_pkg::level_t     level
);

    apb_pkg::apb_state_e state;
    apb_pkg::apb_state_e state_next;

    logic        access;
    logic        data_write;
    logic        bad;
    logic        stall;
    logic [31:0] status;

    always_comb begin
        data_write = 1'b0;
        bad        = 1'b0;
        case (apb_pkg::reg_addr_e'(paddr))
            apb_pkg::REG_DATA:   begin
                data_write = pwrite;
                bad        = !pwrite; // the data register cannot be read back
            end
            apb_pkg::REG_STATUS: bad = pwrite;
            apb_pkg::REG_FLUSH:  bad = 1'b0; // reads return zero
            default:             bad = 1'b1;
        endcase
    end

    assign access = psel && penable && (state != apb_pkg::IDLE);
    assign stall  = data_write && full;

    assign pready    = access && !stall;
    assign pslverr   = pready && bad;
    assign push      = pready && data_write;
    assign push_data = pwdata[`FIFO_WIDTH-1:0];
    assign flush     = pready && pwrite && (paddr == apb_pkg::REG_FLUSH);

    always_comb begin
        status                                   = '0;
        status[$bits(fifo_pkg::level_t)-1:0]     = level;
        status[8]                                = empty;
        status[9]                                = full;
    end

    assign prdata = (pready && !pwrite && paddr == apb_pkg::REG_STATUS) ? status : '0;

    always_comb begin
        state_next = state;
        case (state)
            apb_pkg::IDLE:       if (psel && !penable) state_next = apb_pkg::ACCESS;
            apb_pkg::ACCESS:     if (stall) state_next = apb_pkg::WAIT_SPACE;
                                 else if (pready) state_next = apb_pkg::IDLE;
            apb_pkg::WAIT_SPACE: if (pready) state_next = apb_pkg::IDLE; // pushes once full drops
            default:             state_next = apb_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= apb_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: src/stream_consumer.sv
`default_nettype none

module stream_consumer (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  flush,

    input  wire                  can_pop,
    input  wire fifo_pkg::word_t rd_data,
    output logic                 pop,

    output logic                 out_valid,
    output fifo_pkg::word_t      out_data,
    input  wire                  out_ready
);

    fifo_pkg::cons_state_e state;
    fifo_pkg::cons_state_e state_next;
    fifo_pkg::word_t       data_q;

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        case (state)
            fifo_pkg::EMPTY: begin
                if (can_pop) begin
                    pop        = 1'b1;
                    state_next = fifo_pkg::FETCH;
                end
            end
            fifo_pkg::FETCH: state_next = fifo_pkg::HOLD; // rd_data is valid this cycle
            fifo_pkg::HOLD: begin
                if (out_ready) begin
                    pop        = can_pop; // refill straight away after a transfer
                    state_next = can_pop ? fifo_pkg::FETCH : fifo_pkg::EMPTY;
                end
            end
            default: state_next = fifo_pkg::EMPTY;
        endcase
        if (flush) begin
            pop        = 1'b0;
            state_next = fifo_pkg::EMPTY; // held word is dropped with the rest
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fifo_pkg::EMPTY;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == fifo_pkg::FETCH) begin
            data_q <= rd_data;
        end
    end

    assign out_valid = (state == fifo_pkg::HOLD);
    assign out_data  = data_q;

endmodule

`default_nettype wire

// File: src/apb_fifo_top.sv
`default_nettype none

`include "fifo_config.svh"

module apb_fifo_top (
    input  wire                       clk,
    input  wire                       reset,

    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [`APB_ADDR_WIDTH-1:0] paddr,
    input  wire [31:0]                pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,

    output logic                      out_valid,
    output fifo_pkg::word_t           out_data,
    input  wire                       out_ready
);

    logic             push;
    logic             flush;
    logic             pop;
    logic             full;
    logic             empty;
    logic             can_pop;
    fifo_pkg::word_t  push_data;
    fifo_pkg::word_t  rd_data;
    fifo_pkg::level_t level;

    apb_producer producer (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_data (push_data),
        .flush     (flush),
        .full      (full),
        .empty     (empty),
        .level     (level)
    );

    fifo_buffer buffer (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .flush     (flush),
        .pop       (pop),
        .rd_data   (rd_data),
        .level     (level),
        .full      (full),
        .empty     (empty),
        .can_pop   (can_pop)
    );

    stream_consumer consumer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .can_pop   (can_pop),
        .rd_data   (rd_data),
        .pop       (pop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: tests/apb_fifo_sva.sv
`default_nettype none

module apb_fifo_sva (
    input wire                  clk,
    input wire                  reset,
    input wire                  pready,
    input wire                  pslverr,
    input wire                  push,
    input wire                  flush,
    input wire                  out_valid,
    input wire                  out_ready,
    input wire fifo_pkg::word_t out_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // an offered word stays put until taken unless a flush withdraws it
    hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> !out_valid || $stable(out_data)
    ) else $error("out_data changed while out_valid waited for out_ready");

    // a rejected access completes and leaves the buffer untouched
    error_with_ready: assert property (
        @(posedge clk) pslverr |-> pready && !push && !flush
    ) else $error("pslverr outside a completing APB access or together with a push or flush");

    idle_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid high in the cycle after reset");

endmodule

bind apb_fifo_top apb_fifo_sva sva (
    .clk       (clk),
    .reset     (reset),
    .pready    (pready),
    .pslverr   (pslverr),
    .push      (push),
    .flush     (flush),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

`default_nettype wire

// File: tests/tb_apb_fifo.sv
`default_nettype none

`include "fifo_config.svh"

module tb_apb_fifo;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_WAIT = 1000; // cycles allowed for any single wait
    localparam fifo_pkg::level_t FULL_LEVEL = fifo_pkg::level_t'(1 << `FIFO_DEPTH_LOG2);

    typedef enum {OP_WRITE, OP_READ, OP_DRAIN, OP_STALL} op_e;

    typedef struct {
        string                      name;
        op_e                        op;
        logic [`APB_ADDR_WIDTH-1:0] addr;
        logic [31:0]                wdata;
        logic [31:0]                exp_prdata;
        logic                       exp_err;
        int                         count; // words, transfers or stall cycles
    } step_t;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       out_valid;
    fifo_pkg::word_t            out_data;
    logic                       out_ready;

    step_t           steps[$];
    fifo_pkg::word_t expected_q[$]; // words pushed and not yet taken from the stream
    string           cur_name;
    int              xfer_count;
    logic [31:0]     rng;

    apb_fifo_top DUT (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input fifo_pkg::word_t expected,
                              input fifo_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input fifo_pkg::level_t expected,
                               input fifo_pkg::level_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected level %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_prdata(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // the consumer keeps one word outside the buffer whenever anything is queued
    function automatic fifo_pkg::level_t model_level();
        if (expected_q.size() == 0) begin
            return '0;
        end
        return fifo_pkg::level_t'(expected_q.size() - 1);
    endfunction

    task automatic add_step(input string name, input op_e op,
                            input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_prdata, input logic exp_err, input int count);
        step_t s;
        s.name       = name;
        s.op         = op;
        s.addr       = addr;
        s.wdata      = wdata;
        s.exp_prdata = exp_prdata;
        s.exp_err    = exp_err;
        s.count      = count;
        steps.push_back(s);
    endtask

    // hold is the number of stalled cycles before out_ready is raised to make room
    task automatic apb_access(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                              input logic [31:0] data, input int hold,
                              output logic [31:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            if (waited == MAX_WAIT) begin
                $display("APB access in %s got no pready after %0d cycles", cur_name, waited);
                abort_run();
            end else begin
                waited++;
                @(negedge clk);
                if (hold != 0 && waited >= hold) begin
                    out_ready = 1'b1; // the held word leaves and frees one entry
                end
                @(posedge clk);
            end
        end
        rdata = prdata;
        err   = pslverr;
        if (waited < hold) begin
            $display("Data write in %s completed after %0d cycles while the FIFO was full",
                     cur_name, waited);
            abort_run();
        end else begin
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
            if (hold != 0) begin
                out_ready = 1'b0;
            end
        end
    endtask

    task automatic record_write(input step_t s, input logic [31:0] data, input logic err);
        int waited;
        waited = 0;
        check_bit({s.name, " pslverr"}, s.exp_err, err);
        if (s.addr == apb_pkg::REG_DATA && !err) begin
            expected_q.push_back(fifo_pkg::word_t'(data));
        end
        if (s.addr == apb_pkg::REG_FLUSH && !err) begin
            expected_q.delete();
            while (out_valid) begin
                if (waited == 2) begin
                    $display("out_valid still high two cycles after the flush in %s", s.name);
                    abort_run();
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end
        end
    endtask

    task automatic drain(input string name, input int count);
        int target;
        int waited;
        target = xfer_count + ((count == 0) ? expected_q.size() : count);
        waited = 0;
        @(negedge clk);
        while (xfer_count < target) begin
            if (waited == MAX_WAIT) begin
                $display("Drain in %s stalled with %0d words still expected",
                         name, target - xfer_count);
                abort_run();
            end else begin
                rng       = xorshift(rng);
                out_ready = rng[0];
                waited++;
                @(negedge clk);
            end
        end
        out_ready = 1'b0;
        if (count == 0) begin
            @(negedge clk); // a word left in the buffer would be on out_valid by now
            check_bit({name, " out_valid"}, 1'b0, out_valid);
        end
    endtask

    task automatic run_step(input step_t s);
        logic [31:0]      rdata;
        logic             err;
        fifo_pkg::level_t exp_level;
        cur_name = s.name;
        case (s.op)
            OP_WRITE: begin
                for (int k = 0; k < s.count; k++) begin
                    apb_access(1'b1, s.addr, s.wdata + 32'(k), 0, rdata, err);
                    record_write(s, s.wdata + 32'(k), err);
                end
            end
            OP_STALL: begin
                apb_access(1'b1, s.addr, s.wdata, s.count, rdata, err);
                record_write(s, s.wdata, err);
            end
            OP_READ: begin
                apb_access(1'b0, s.addr, 32'h0, 0, rdata, err);
                check_bit({s.name, " pslverr"}, s.exp_err, err);
                if (s.addr == apb_pkg::REG_STATUS) begin
                    exp_level = model_level();
                    check_level(s.name, exp_level, fifo_pkg::level_t'(rdata));
                    check_bit({s.name, " empty"}, exp_level == '0, rdata[8]);
                    check_bit({s.name, " full"}, exp_level == FULL_LEVEL, rdata[9]);
                end else begin
                    check_prdata(s.name, s.exp_prdata, rdata);
                end
            end
            default: drain(s.name, s.count);
        endcase
    endtask

    // every accepted stream word must be the oldest one still expected
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("Stream delivered a word in %s although none was pending", cur_name);
                abort_run();
            end else begin
                check_word(cur_name, expected_q.pop_front(), out_data);
                xfer_count++;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        out_ready  = 1'b0;
        xfer_count = 0;
        rng        = 32'hef568ab2;
        cur_name   = "reset";

        add_step("reset_status", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("order_push", OP_WRITE, apb_pkg::REG_DATA, 32'h0_1000, 0, 1'b0, 10);
        add_step("order_status", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("order_drain", OP_DRAIN, '0, 0, 0, 1'b0, 0);
        add_step("order_empty", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("level_push", OP_WRITE, apb_pkg::REG_DATA, 32'h2_2000, 0, 1'b0, 6);
        add_step("level_after_push", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("level_drain_two", OP_DRAIN, '0, 0, 0, 1'b0, 2);
        add_step("level_after_drain", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("level_drain_rest", OP_DRAIN, '0, 0, 0, 1'b0, 0);
        add_step("full_fill", OP_WRITE, apb_pkg::REG_DATA, 32'hcafe_3000, 0, 1'b0, 33);
        add_step("full_status", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("full_stall", OP_STALL, apb_pkg::REG_DATA, 32'h3_4000, 0, 1'b0, 5);
        add_step("full_drain", OP_DRAIN, '0, 0, 0, 1'b0, 0);
        add_step("full_after", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("flush_push", OP_WRITE, apb_pkg::REG_DATA, 32'h4_4000, 0, 1'b0, 5);
        add_step("flush_cmd", OP_WRITE, apb_pkg::REG_FLUSH, 0, 0, 1'b0, 1);
        add_step("flush_status", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("flush_refill", OP_WRITE, apb_pkg::REG_DATA, 32'h5_5000, 0, 1'b0, 3);
        add_step("flush_drain", OP_DRAIN, '0, 0, 0, 1'b0, 0);
        add_step("flush_read_back", OP_READ, apb_pkg::REG_FLUSH, 0, 0, 1'b0, 0);
        add_step("error_push", OP_WRITE, apb_pkg::REG_DATA, 32'h6_6000, 0, 1'b0, 4);
        add_step("error_status_before", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("error_read_data", OP_READ, apb_pkg::REG_DATA, 0, 0, 1'b1, 0);
        add_step("error_write_status", OP_WRITE, apb_pkg::REG_STATUS, 32'hffff, 0, 1'b1, 1);
        add_step("error_read_unmapped", OP_READ, 4'hc, 0, 0, 1'b1, 0);
        add_step("error_write_unmapped", OP_WRITE, 4'hc, 32'h1234, 0, 1'b1, 1);
        add_step("error_status_after", OP_READ, apb_pkg::REG_STATUS, 0, 0, 1'b0, 0);
        add_step("error_drain", OP_DRAIN, '0, 0, 0, 1'b0, 0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset pready", 1'b0, pready);
        check_bit("reset pslverr", 1'b0, pslverr);

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        if (expected_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("%0d pushed words never left the stream", expected_q.size());
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
src/apb_pkg.sv
src/fifo_pkg.sv
src/memory_block.sv
src/fifo_buffer.sv
src/apb_producer.sv
src/stream_consumer.sv
src/apb_fifo_top.sv
tests/apb_fifo_sva.sv
tests/tb_apb_fifo.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_apb_fifo
FILELIST = all.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# the binary exits with a failing status when the testbench stops on $fatal
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
